// File: pt_entry_decode.sv
module pt_entry_decode
#(
    parameter int LINE_WORDS = 8,
    localparam int WORD_IDX_BITS = $clog2(LINE_WORDS)
)
(
    input  logic                               clk,
    input  logic                               reset,

    // Read response line from memory
    input  pt_pkg::pt_word_t [LINE_WORDS-1:0]  pt_read_data,
    input  logic                               pt_read_data_en,

    // Entry position within the line, from the FSM
    input  logic [WORD_IDX_BITS-1:0]           word_idx,

    // Selected entry, valid for one cycle
    output logic                               entry_valid,
    output pt_pkg::pt_entry_t                  entry
);

    import pt_pkg::*;

    // Registered copy of the response line
    pt_word_t [LINE_WORDS-1:0] line_q;
    logic                      line_en_q;

    // Entry picked out of the registered line
    pt_word_t sel_word;

    // Strobe follows the line by one register stage
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            line_en_q <= 1'b0;
        end
        else
        begin
            line_en_q <= pt_read_data_en;
        end
    end

    // Line data only captured when a response arrives
    always_ff @(posedge clk)
    begin
        if (pt_read_data_en)
        begin
            line_q <= pt_read_data;
        end
    end

    // Word select, index stays stable while the read is outstanding
    assign sel_word = line_q[word_idx];

    // Page pointer and status bits
    assign entry       = pt_word_to_entry(sel_word);
    assign entry_valid = line_en_q;

endmodule

// File: pt_pkg.sv
package pt_pkg;

    // ============================================================
    // Table geometry
    // ============================================================

    // Each level is one 4 KB page holding 512 entries
    localparam int PT_IDX_BITS = 9;
    typedef logic [PT_IDX_BITS-1:0] pt_idx_t;

    // Root plus three more levels of indirection
    localparam int PT_LEVELS = 4;

    // One index per level, root index in the top slot
    typedef pt_idx_t [PT_LEVELS-1:0] pt_idx_vec_t;

    // Current level of the walk, 0 is the root
    typedef logic [$clog2(PT_LEVELS)-1:0] pt_depth_t;

    // Deepest level, a leaf is required here
    localparam pt_depth_t PT_LAST_DEPTH = pt_depth_t'(PT_LEVELS - 1);

    // Leaf one level above the last maps a 2 MB page
    localparam pt_depth_t PT_BIG_PAGE_DEPTH = pt_depth_t'(PT_LEVELS - 2);

    // ============================================================
    // Entry layout
    // ============================================================

    typedef logic [63:0] pt_word_t;

    // Status lives in the two low bits of every entry
    typedef struct packed
    {
        logic error;     // bit 1, entry invalid or missing
        logic terminal;  // bit 0, entry is the translation
    }
    pt_status_t;

    // Page pointer plus status, bits 47:12 and 1:0
    typedef struct packed
    {
        vtp_pkg::pa_page_t page;
        pt_status_t        status;
    }
    pt_entry_t;

    // Split a raw 64-bit word into page and status
    function automatic pt_entry_t pt_word_to_entry(pt_word_t w);
        pt_entry_t e;
        e.page            = w[vtp_pkg::PAGE_OFFSET_BITS +: $bits(vtp_pkg::pa_page_t)];
        e.status.error    = w[1];
        e.status.terminal = w[0];
        return e;
    endfunction

    // ============================================================
    // Walk FSM
    // ============================================================

    typedef enum logic [2:0]
    {
        IDLE,
        READ_REQ,
        WAIT_RSP,
        CHECK,
        DONE,
        ERROR
    }
    pt_walk_state_t;

endpackage

// File: pt_walk_fsm.sv
module pt_walk_fsm
#(
    parameter int LINE_WORDS = 8,
    localparam int WORD_IDX_BITS = $clog2(LINE_WORDS)
)
(
    input  logic                     clk,
    input  logic                     reset,

    // Enable level and table root
    input  logic                     walk_enable,
    input  vtp_pkg::pa_page_t        pt_root,

    // Walk request
    input  logic                     req_en,
    input  vtp_pkg::va_page_t        req_va,
    output logic                     req_rdy,

    // Page table line reads
    output logic                     pt_read_en,
    output vtp_pkg::line_addr_t      pt_read_addr,
    input  logic                     pt_read_rdy,

    // Decoded entry from the response path
    output logic [WORD_IDX_BITS-1:0] word_idx,
    input  logic                     entry_valid,
    input  pt_pkg::pt_entry_t        entry,

    // Result handshake
    input  logic                     fill_en,
    output logic                     walk_done,
    output logic                     walk_error,
    output vtp_pkg::va_page_t        done_va,
    output vtp_pkg::pa_page_t        done_pa,
    output pt_pkg::pt_depth_t        done_depth
);

    import pt_pkg::*;
    import vtp_pkg::*;

    // Index of a line within one table page
    localparam int LINE_IDX_BITS = PT_IDX_BITS - WORD_IDX_BITS;

    pt_walk_state_t state;
    logic           initialized;
    logic           req_accept;

    // Walk context
    va_page_t    walk_va;
    pa_page_t    cur_page;    // table page being read, leaf page at the end
    pt_idx_vec_t idx_vec;     // index of the current level in the top slot
    pt_depth_t   depth;
    pt_entry_t   rsp_entry;

    // Split of the current level's index
    pt_idx_t                  top_idx;
    logic [LINE_IDX_BITS-1:0] line_idx;

    // Outcome of the entry under check
    logic chk_error;
    logic chk_done;

    // ============================================================
    // Request and FSM
    // ============================================================

    // One walk at a time, only from IDLE
    assign req_rdy    = initialized && (state == IDLE);
    assign req_accept = req_en && req_rdy;

    // Error bit, or still a pointer at the deepest level
    assign chk_error = rsp_entry.status.error ||
                       (!rsp_entry.status.terminal && (depth == PT_LAST_DEPTH));
    assign chk_done  = !chk_error && rsp_entry.status.terminal;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= IDLE;
            initialized <= 1'b0;
        end
        else
        begin
            initialized <= walk_enable;

            case (state)
                IDLE:
                begin
                    if (req_accept)
                    begin
                        state <= READ_REQ;
                    end
                end
                READ_REQ:
                begin
                    // Hold here under read back-pressure
                    if (pt_read_rdy)
                    begin
                        state <= WAIT_RSP;
                    end
                end
                WAIT_RSP:
                begin
                    if (entry_valid)
                    begin
                        state <= CHECK;
                    end
                end
                CHECK:
                begin
                    if (chk_error)
                    begin
                        state <= ERROR;
                    end
                    else if (chk_done)
                    begin
                        state <= DONE;
                    end
                    else
                    begin
                        state <= READ_REQ;
                    end
                end
                DONE:
                begin
                    // Released once the result has been filled
                    if (fill_en)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    // ERROR holds until reset
                    state <= ERROR;
                end
            endcase
        end
    end

    // Walk context updates
    always_ff @(posedge clk)
    begin
        case (state)
            IDLE:
            begin
                // VA page index is exactly the four level indices
                if (req_accept)
                begin
                    walk_va  <= req_va;
                    idx_vec  <= pt_idx_vec_t'(req_va);
                    depth    <= '0;
                    cur_page <= pt_root;
                end
            end
            WAIT_RSP:
            begin
                if (entry_valid)
                begin
                    rsp_entry <= entry;
                end
            end
            CHECK:
            begin
                cur_page <= rsp_entry.page;

                // Next level's index moves into the top slot
                if (!chk_error && !chk_done)
                begin
                    idx_vec <= {idx_vec[PT_LEVELS-2:0], pt_idx_t'(0)};
                    depth   <= depth + pt_depth_t'(1);
                end
            end
            default:
            begin
            end
        endcase
    end

    // ============================================================
    // Read address
    // ============================================================

    assign top_idx  = idx_vec[PT_LEVELS-1];
    assign line_idx = top_idx[PT_IDX_BITS-1 -: LINE_IDX_BITS];
    assign word_idx = top_idx[WORD_IDX_BITS-1:0];

    assign pt_read_en   = (state == READ_REQ) && pt_read_rdy;
    assign pt_read_addr = line_addr_t'({cur_page, line_idx});

    // ============================================================
    // Walk outcome
    // ============================================================

    // Pulses during the single CHECK cycle
    assign walk_done  = (state == CHECK) && chk_done;
    assign walk_error = (state == CHECK) && chk_error;

    assign done_va    = walk_va;
    assign done_pa    = rsp_entry.page;
    assign done_depth = depth;

endmodule

// File: pt_walk_result.sv
module pt_walk_result
(
    input  logic              clk,
    input  logic              reset,

    // Walk outcome from the FSM
    input  logic              walk_done,
    input  logic              walk_error,
    input  vtp_pkg::va_page_t done_va,
    input  vtp_pkg::pa_page_t done_pa,
    input  pt_pkg::pt_depth_t done_depth,

    // Fill towards the TLB
    input  logic              fill_rdy,
    output logic              fill_en,
    output vtp_pkg::va_page_t fill_va,
    output vtp_pkg::pa_page_t fill_pa,
    output logic              fill_big_page,

    // Sticky missing-translation flag
    output logic              not_present
);

    import pt_pkg::*;

    // A finished translation is waiting for its fill
    logic res_valid;

    // Offered while held, fired when the TLB can take it
    assign fill_en = res_valid && fill_rdy;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            res_valid   <= 1'b0;
            not_present <= 1'b0;
        end
        else
        begin
            if (walk_done)
            begin
                res_valid <= 1'b1;
            end
            else if (fill_en)
            begin
                res_valid <= 1'b0;
            end

            // Stays set until reset
            if (walk_error)
            begin
                not_present <= 1'b1;
            end
        end
    end

    // Translation held stable until consumed
    always_ff @(posedge clk)
    begin
        if (walk_done)
        begin
            fill_va       <= done_va;
            fill_pa       <= done_pa;
            fill_big_page <= (done_depth == PT_BIG_PAGE_DEPTH);
        end
    end

endmodule

// File: pt_walk_top.sv
module pt_walk_top
#(
    parameter int LINE_WORDS = 8
)
(
    input  logic                              clk,
    input  logic                              reset,

    // Enable level and table root
    input  logic                              walk_enable,
    input  vtp_pkg::pa_page_t                 pt_root,

    // Walk request
    input  logic                              req_en,
    input  vtp_pkg::va_page_t                 req_va,
    output logic                              req_rdy,

    // Page table reads
    output logic                              pt_read_en,
    output vtp_pkg::line_addr_t               pt_read_addr,
    input  logic                              pt_read_rdy,
    input  pt_pkg::pt_word_t [LINE_WORDS-1:0] pt_read_data,
    input  logic                              pt_read_data_en,

    // Translation fill
    output logic                              fill_en,
    output vtp_pkg::va_page_t                 fill_va,
    output vtp_pkg::pa_page_t                 fill_pa,
    output logic                              fill_big_page,
    input  logic                              fill_rdy,

    // Walk hit a missing entry
    output logic                              not_present
);

    import pt_pkg::*;
    import vtp_pkg::*;

    localparam int WORD_IDX_BITS = $clog2(LINE_WORDS);

    // Decode to FSM
    logic                     entry_valid;
    pt_entry_t                entry;
    logic [WORD_IDX_BITS-1:0] word_idx;

    // FSM to result
    logic      walk_done;
    logic      walk_error;
    va_page_t  done_va;
    pa_page_t  done_pa;
    pt_depth_t done_depth;

    pt_entry_decode #(
        .LINE_WORDS (LINE_WORDS)
    ) i_decode (
        .clk             (clk),
        .reset           (reset),
        .pt_read_data    (pt_read_data),
        .pt_read_data_en (pt_read_data_en),
        .word_idx        (word_idx),
        .entry_valid     (entry_valid),
        .entry           (entry)
    );

    pt_walk_fsm #(
        .LINE_WORDS (LINE_WORDS)
    ) i_fsm (
        .clk          (clk),
        .reset        (reset),
        .walk_enable  (walk_enable),
        .pt_root      (pt_root),
        .req_en       (req_en),
        .req_va       (req_va),
        .req_rdy      (req_rdy),
        .pt_read_en   (pt_read_en),
        .pt_read_addr (pt_read_addr),
        .pt_read_rdy  (pt_read_rdy),
        .word_idx     (word_idx),
        .entry_valid  (entry_valid),
        .entry        (entry),
        .fill_en      (fill_en),
        .walk_done    (walk_done),
        .walk_error   (walk_error),
        .done_va      (done_va),
        .done_pa      (done_pa),
        .done_depth   (done_depth)
    );

    pt_walk_result i_result (
        .clk           (clk),
        .reset         (reset),
        .walk_done     (walk_done),
        .walk_error    (walk_error),
        .done_va       (done_va),
        .done_pa       (done_pa),
        .done_depth    (done_depth),
        .fill_rdy      (fill_rdy),
        .fill_en       (fill_en),
        .fill_va       (fill_va),
        .fill_pa       (fill_pa),
        .fill_big_page (fill_big_page),
        .not_present   (not_present)
    );

endmodule

// File: run.sh
#!/bin/sh
# Compile and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_pt_walk -f vlog.f -o sim_pt_walk \
    && ./obj_dir/sim_pt_walk > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "STATUS: FAIL" sim.log && exit 1 \
    || grep -q "STATUS: PASS" sim.log || exit 1

// File: tb_pt_mem.sv
module tb_pt_mem
#(
    parameter int LINE_WORDS = 8,
    localparam int WORD_IDX_BITS = $clog2(LINE_WORDS)
)
(
    input  logic                              clk,
    input  logic                              reset,

    // Table load port, one entry per cycle
    input  logic                              wr_en,
    input  vtp_pkg::line_addr_t               wr_line,
    input  logic [WORD_IDX_BITS-1:0]          wr_word,
    input  pt_pkg::pt_word_t                  wr_data,

    // Latency for the next accepted read, 1 to 6 cycles
    input  logic [2:0]                        rsp_delay,

    // Read port facing the walker
    input  logic                              rd_en,
    input  vtp_pkg::line_addr_t               rd_addr,
    output pt_pkg::pt_word_t [LINE_WORDS-1:0] rd_data,
    output logic                              rd_data_en
);

    timeunit 1ns;
    timeprecision 100ps;

    import pt_pkg::*;
    import vtp_pkg::*;

    typedef pt_word_t [LINE_WORDS-1:0] line_t;

    // Sparse table, lines never written read back as zero
    line_t lines [line_addr_t];

    line_t      wr_tmp;
    line_addr_t pend_addr;
    int         pend_cnt = 0;
    logic       busy = 1'b0;

    // Response decided at the rising edge, driven at the falling edge
    logic  fire = 1'b0;
    line_t fire_line = '0;
    logic  rsp_en_q = 1'b0;
    line_t rsp_line_q = '0;

    always @(posedge clk)
    begin
        // Merge one entry into its line
        if (wr_en)
        begin
            wr_tmp          = lines.exists(wr_line) ? lines[wr_line] : '0;
            wr_tmp[wr_word] = wr_data;
            lines[wr_line]  = wr_tmp;
        end

        fire = 1'b0;
        if (reset)
        begin
            busy = 1'b0;
        end
        else if (rd_en)
        begin
            busy      = 1'b1;
            pend_addr = rd_addr;
            pend_cnt  = int'(rsp_delay);
        end
        else if (busy)
        begin
            pend_cnt = pend_cnt - 1;
            if (pend_cnt == 0)
            begin
                fire      = 1'b1;
                busy      = 1'b0;
                fire_line = lines.exists(pend_addr) ? lines[pend_addr] : '0;
            end
        end
    end

    // One-cycle strobe with the line
    always @(negedge clk)
    begin
        rsp_en_q <= fire;
        if (fire)
        begin
            rsp_line_q <= fire_line;
        end
    end

    assign rd_data    = rsp_line_q;
    assign rd_data_en = rsp_en_q;

endmodule

// File: tb_pt_walk.sv
module tb_pt_walk;

    timeunit 1ns;
    timeprecision 100ps;

    import pt_pkg::*;
    import vtp_pkg::*;

    localparam int LINE_WORDS     = 8;
    localparam int WORD_IDX_BITS  = $clog2(LINE_WORDS);
    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_WALKS      = 40;
    localparam int ERROR_LEVEL    = 2;
    localparam int HOLD_CYCLES    = 50;
    localparam int TIMEOUT_CYCLES =
        RESET_CYCLES + 4 * (NUM_WALKS + 1) + 200 * (NUM_WALKS + 1) + HOLD_CYCLES + 20;

    // Entry address in the model is the table page joined with its index
    typedef logic [$bits(pa_page_t)+PT_IDX_BITS-1:0] entry_key_t;

    // DUT ports
    logic                            clk;
    logic                            reset;
    logic                            walk_enable;
    pa_page_t                        pt_root;
    logic                            req_en;
    va_page_t                        req_va;
    logic                            req_rdy;
    logic                            pt_read_en;
    line_addr_t                      pt_read_addr;
    logic                            pt_read_rdy;
    pt_word_t [LINE_WORDS-1:0]       pt_read_data;
    logic                            pt_read_data_en;
    logic                            fill_en;
    va_page_t                        fill_va;
    pa_page_t                        fill_pa;
    logic                            fill_big_page;
    logic                            fill_rdy;
    logic                            not_present;

    // Table load and latency control of the memory model
    logic                            mem_wr_en;
    line_addr_t                      mem_wr_line;
    logic [WORD_IDX_BITS-1:0]        mem_wr_word;
    pt_word_t                        mem_wr_data;
    logic [2:0]                      mem_delay;

    logic [31:0] rng_state = 32'd9;

    // Reference table and the requests to run against it
    pt_word_t   model_tbl [entry_key_t];
    pa_page_t   pool_base;
    int         pool_next;
    va_page_t   walk_vas [NUM_WALKS];
    va_page_t   err_va;

    // Expected outcome of the walk in flight
    line_addr_t exp_addr_q [$];
    int         exp_nreads = 0;
    va_page_t   exp_va;
    pa_page_t   exp_pa;
    logic       exp_big;
    logic       exp_err = 1'b0;

    // Monitor bookkeeping
    int cycle_count = 0;
    int reads_open  = 0;
    int rsp_count   = 0;
    int offer_age   = -1;
    int fill_count  = 0;
    int big_fills   = 0;
    int small_fills = 0;

    pt_walk_top #(
        .LINE_WORDS (LINE_WORDS)
    ) i_dut (
        .clk             (clk),
        .reset           (reset),
        .walk_enable     (walk_enable),
        .pt_root         (pt_root),
        .req_en          (req_en),
        .req_va          (req_va),
        .req_rdy         (req_rdy),
        .pt_read_en      (pt_read_en),
        .pt_read_addr    (pt_read_addr),
        .pt_read_rdy     (pt_read_rdy),
        .pt_read_data    (pt_read_data),
        .pt_read_data_en (pt_read_data_en),
        .fill_en         (fill_en),
        .fill_va         (fill_va),
        .fill_pa         (fill_pa),
        .fill_big_page   (fill_big_page),
        .fill_rdy        (fill_rdy),
        .not_present     (not_present)
    );

    tb_pt_mem #(
        .LINE_WORDS (LINE_WORDS)
    ) i_mem (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (mem_wr_en),
        .wr_line    (mem_wr_line),
        .wr_word    (mem_wr_word),
        .wr_data    (mem_wr_data),
        .rsp_delay  (mem_delay),
        .rd_en      (pt_read_en),
        .rd_addr    (pt_read_addr),
        .rd_data    (pt_read_data),
        .rd_data_en (pt_read_data_en)
    );

    // ============================================================
    // Random numbers and error exit
    // ============================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rnd();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic pa_page_t rand_page();
        return pa_page_t'({rnd(), rnd()});
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // ============================================================
    // Table construction and reference walk
    // ============================================================

    // New entry for a level with random junk in the reserved bits
    function automatic pt_word_t make_entry(input int lvl, input int err_level);
        pt_word_t w;
        pa_page_t page;
        w      = {rnd(), rnd()};
        w[1:0] = 2'b00;
        if (lvl == err_level)
        begin
            page = rand_page();
            w[1] = 1'b1;
        end
        else if (lvl == PT_LEVELS - 1 || (lvl == PT_LEVELS - 2 && (rnd() % 2) == 1))
        begin
            // 4 KB leaf at the last level and 2 MB leaf one above
            page = rand_page();
            w[0] = 1'b1;
        end
        else
        begin
            // Pointer to a fresh table page from the pool
            page      = pool_base + pa_page_t'(pool_next);
            pool_next = pool_next + 1;
        end
        w[PAGE_OFFSET_BITS +: $bits(pa_page_t)] = page;
        return w;
    endfunction

    // Fill in whatever the path of one VA still lacks
    function automatic void build_path(input va_page_t va, input int err_level);
        pt_idx_vec_t idx;
        pa_page_t    page;
        entry_key_t  key;
        pt_word_t    w;
        int          lvl;
        logic        stop;
        idx  = pt_idx_vec_t'(va);
        page = pool_base;
        stop = 1'b0;
        for (lvl = 0; lvl < PT_LEVELS && !stop; lvl++)
        begin
            key = {page, idx[PT_LEVELS-1]};
            if (!model_tbl.exists(key))
            begin
                model_tbl[key] = make_entry(lvl, err_level);
            end
            w    = model_tbl[key];
            stop = w[1] || w[0];
            page = w[PAGE_OFFSET_BITS +: $bits(pa_page_t)];
            idx  = {idx[PT_LEVELS-2:0], pt_idx_t'(0)};
        end
    endfunction

    // Expected line reads and result of one walk
    function automatic void ref_walk(input va_page_t va);
        pt_idx_vec_t idx;
        pa_page_t    page;
        entry_key_t  key;
        pt_word_t    w;
        int          lvl;
        logic        stop;
        idx        = pt_idx_vec_t'(va);
        page       = pt_root;
        stop       = 1'b0;
        exp_va     = va;
        exp_err    = 1'b0;
        exp_nreads = 0;
        exp_addr_q.delete();
        for (lvl = 0; lvl < PT_LEVELS && !stop; lvl++)
        begin
            key = {page, idx[PT_LEVELS-1]};
            exp_addr_q.push_back(line_addr_t'(key >> WORD_IDX_BITS));
            exp_nreads = exp_nreads + 1;
            w    = model_tbl[key];
            page = w[PAGE_OFFSET_BITS +: $bits(pa_page_t)];
            if (w[1] || (!w[0] && lvl == PT_LEVELS - 1))
            begin
                exp_err = 1'b1;
                stop    = 1'b1;
            end
            else if (w[0])
            begin
                exp_pa  = page;
                exp_big = (lvl == PT_LEVELS - 2);
                stop    = 1'b1;
            end
            idx = {idx[PT_LEVELS-2:0], pt_idx_t'(0)};
        end
    endfunction

    // Copy every model entry into the memory
    task automatic load_table();
        entry_key_t key;
        if (model_tbl.first(key))
        begin
            do
            begin
                @(negedge clk);
                mem_wr_en   = 1'b1;
                mem_wr_line = line_addr_t'(key >> WORD_IDX_BITS);
                mem_wr_word = key[WORD_IDX_BITS-1:0];
                mem_wr_data = model_tbl[key];
            end
            while (model_tbl.next(key));
        end
        @(negedge clk);
        mem_wr_en = 1'b0;
    endtask

    // Called at a falling edge and holds req_en for one accepting edge
    task automatic issue_request(input va_page_t va);
        while (!req_rdy)
        begin
            @(negedge clk);
        end
        ref_walk(va);
        rsp_count = 0;
        offer_age = -1;
        req_en    = 1'b1;
        req_va    = va;
        @(negedge clk);
        req_en = 1'b0;
    endtask

    // ============================================================
    // Clock, random back-pressure and watchdog
    // ============================================================

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Ready lines low about 30% of the time
    initial
    begin
        logic [31:0] r;
        pt_read_rdy = 1'b0;
        fill_rdy    = 1'b0;
        mem_delay   = 3'd1;
        forever
        begin
            @(negedge clk);
            r           = rnd();
            pt_read_rdy = (r % 10) >= 3;
            fill_rdy    = ((r >> 8) % 10) >= 3;
            mem_delay   = 3'(1 + ((r >> 16) % 6));
        end
    end

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        stop_on_error("Timeout, the walker stopped making progress");
    end

    // ============================================================
    // Monitor sampled at the rising edge
    // ============================================================

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;

        // Quiet outputs in reset and before enable
        if ((reset || !walk_enable) && cycle_count > 1)
        begin
            assert (!req_rdy && !pt_read_en && !fill_en && !not_present)
            else stop_on_error("Walker outputs active during reset or while disabled");
        end

        assert (!(pt_read_en && !pt_read_rdy))
        else stop_on_error("Read issued while pt_read_rdy was low");
        assert (!(fill_en && !fill_rdy))
        else stop_on_error("Fill issued while fill_rdy was low");

        if (offer_age >= 0)
        begin
            offer_age = offer_age + 1;
        end

        // Result is offered three edges after the last response
        if (pt_read_data_en)
        begin
            reads_open = reads_open - 1;
            rsp_count  = rsp_count + 1;
            if (rsp_count == exp_nreads && !exp_err)
            begin
                offer_age = 0;
            end
        end

        if (pt_read_en)
        begin
            assert (reads_open == 0)
            else stop_on_error("Second read issued while one was outstanding");
            assert (exp_addr_q.size() != 0)
            else stop_on_error("More reads than the walk needs");
            if (exp_addr_q.size() != 0)
            begin
                assert (pt_read_addr == exp_addr_q[0])
                else stop_on_error($sformatf("Fail at %0d ns: read address %h, expected %h",
                                             $time, pt_read_addr, exp_addr_q[0]));
                void'(exp_addr_q.pop_front());
            end
            reads_open = reads_open + 1;
        end

        // Offered translation must be right and stay put until taken
        if (offer_age >= 3)
        begin
            assert (fill_va == exp_va && fill_pa == exp_pa && fill_big_page == exp_big)
            else stop_on_error($sformatf(
                "Fail at %0d ns: fill %h to %h big %0b, expected %h to %h big %0b",
                $time, fill_va, fill_pa, fill_big_page, exp_va, exp_pa, exp_big));
        end

        if (fill_en)
        begin
            assert (offer_age >= 3)
            else stop_on_error("Fill issued with no finished walk pending");
            if (fill_big_page)
            begin
                big_fills = big_fills + 1;
            end
            else
            begin
                small_fills = small_fills + 1;
            end
            fill_count = fill_count + 1;
            offer_age  = -1;
        end

        if (not_present)
        begin
            assert (exp_err)
            else stop_on_error("not_present raised on a walk with no error entry");
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================

    initial
    begin
        pt_idx_vec_t idx;
        reset       = 1'b1;
        walk_enable = 1'b0;
        req_en      = 1'b0;
        req_va      = '0;
        mem_wr_en   = 1'b0;
        mem_wr_line = '0;
        mem_wr_word = '0;
        mem_wr_data = '0;

        // Root is the first pool page
        pool_base = rand_page();
        pool_next = 1;
        pt_root   = pool_base;

        // Top two indices from a small set so upper tables are shared
        for (int i = 0; i < NUM_WALKS; i++)
        begin
            idx         = pt_idx_vec_t'({rnd(), rnd()});
            idx[3]      = pt_idx_t'(rnd() % 4);
            idx[2]      = pt_idx_t'(rnd() % 4);
            walk_vas[i] = va_page_t'(idx);
            build_path(walk_vas[i], -1);
        end

        // Unused root slot keeps the error path apart
        idx    = pt_idx_vec_t'({rnd(), rnd()});
        idx[3] = '1;
        err_va = va_page_t'(idx);
        build_path(err_va, ERROR_LEVEL);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        load_table();
        walk_enable = 1'b1;

        for (int i = 0; i < NUM_WALKS; i++)
        begin
            issue_request(walk_vas[i]);
            while (fill_count == i)
            begin
                @(negedge clk);
            end
        end

        issue_request(err_va);
        while (!not_present)
        begin
            @(negedge clk);
        end
        assert (exp_err && rsp_count == exp_nreads && exp_addr_q.size() == 0)
        else stop_on_error("Error walk stopped with reads missing");

        // Sticky error blocks new requests
        repeat (HOLD_CYCLES)
        begin
            @(negedge clk);
            assert (not_present && !req_rdy)
            else stop_on_error("not_present dropped or req_rdy rose after the error");
        end

        assert (big_fills > 0 && small_fills > 0)
        else stop_on_error("Random table gave no 2 MB or no 4 KB leaf");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: vlog.f
vtp_pkg.sv
pt_pkg.sv
pt_entry_decode.sv
pt_walk_fsm.sv
pt_walk_result.sv
pt_walk_top.sv
tb_pt_mem.sv
tb_pt_walk.sv

// File: vtp_pkg.sv
package vtp_pkg;

    // ============================================================
    // Address geometry
    // ============================================================

    // Byte offset within a 4 KB page
    localparam int PAGE_OFFSET_BITS = 12;

    // Byte offset within a 64-byte line
    localparam int LINE_OFFSET_BITS = 6;

    // Virtual and physical addresses are both 48 bits
    localparam int ADDR_BITS = 48;

    // ============================================================
    // Page and line indices
    // ============================================================

    // 4 KB virtual page index, the VA without its page offset
    typedef logic [ADDR_BITS-PAGE_OFFSET_BITS-1:0] va_page_t;

    // 4 KB physical page index
    typedef logic [ADDR_BITS-PAGE_OFFSET_BITS-1:0] pa_page_t;

    // Physical address of one 64-byte line
    // Page table reads are issued at this granularity
    typedef logic [ADDR_BITS-LINE_OFFSET_BITS-1:0] line_addr_t;

endpackage
